//--- tb/cdc_reg_testdata.hex
// Columns: write flag, byte address, write data (ignored on reads), expected pslverr
// A write flag of ff ends the stimulus
// Array after reset
0 00 00000000 0
0 04 00000000 0
0 08 00000000 0
0 0c 00000000 0
0 10 00000000 0
0 14 00000000 0
0 18 00000000 0
0 1c 00000000 0
// Fill every word
1 00 a5a5a5a5 0
1 04 01234567 0
1 08 89abcdef 0
1 0c deadbeef 0
1 10 00ff00ff 0
1 14 13579bdf 0
1 18 fedcba98 0
1 1c 7e57c0de 0
// Read back in another order
0 1c 00000000 0
0 08 00000000 0
0 14 00000000 0
0 00 00000000 0
0 10 00000000 0
0 04 00000000 0
0 18 00000000 0
0 0c 00000000 0
// Unmapped and unaligned, then array unchanged
0 28 00000000 1
1 40 cafef00d 1
0 05 00000000 1
1 1e 55aa55aa 1
0 1c 00000000 0
0 00 00000000 0
// Counters, clear, counting again
0 20 00000000 0
0 24 00000000 0
1 24 00000000 0
0 20 00000000 0
0 24 00000000 0
1 08 0badcafe 0
0 08 00000000 0
0 20 00000000 0
0 24 00000000 0
ff 00 00000000 0

//--- compile.f
common/cdc_reg_pkg.sv
sync_reqack/sync_reqack.sv
hdl/apb_req_fsm.sv
hdl/dst_reg_file.sv
hdl/access_counter.sv
hdl/cdc_reg_bridge.sv
tb/tb_cdc_reg_bridge.sv

//--- Makefile
# Verilator lint and simulation of the CDC register bridge
TOP := tb_cdc_reg_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module cdc_reg_bridge

# Pass only if the testbench printed its pass message
sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "Result: PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_cdc_reg_bridge.sv
/*
 * Testbench for the CDC register bridge
 * Two free-running clocks, an APB master fed from the data file and a
 * reference model of the register map that predicts every completion
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_reg_bridge;

  localparam int          MaxLines   = 64;
  localparam int          TimeoutCyc = 100;
  localparam logic [31:0] EndMark    = 32'hff;

  logic               clk_src;
  logic               clk_dst;
  logic               rst_src_n;
  logic               rst_dst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  cdc_reg_pkg::addr_t paddr;
  cdc_reg_pkg::data_t pwdata;
  logic               pready;
  cdc_reg_pkg::data_t prdata;
  logic               pslverr;

  // Four words per access line
  logic [31:0] vec_mem [4*MaxLines];

  // Reference model of the destination side
  logic [31:0] model_regs [8];
  logic [15:0] model_wr_cnt;
  logic [15:0] model_rd_cnt;

  integer seed;

  cdc_reg_bridge u_cdc_reg_bridge (
    .clk_src_i  (clk_src),
    .rst_src_ni (rst_src_n),
    .clk_dst_i  (clk_dst),
    .rst_dst_ni (rst_dst_n),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .pready_o   (pready),
    .prdata_o   (prdata),
    .pslverr_o  (pslverr)
  );

  // 20 ns source clock and 14 ns destination clock
  always #10 clk_src = ~clk_src;
  always #7 clk_dst = ~clk_dst;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s actual 0x%08h expected 0x%08h",
                          name, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model of the register map decode
  //////////////////////////////////////////////////////////////////////

  task automatic model_access(input logic write, input cdc_reg_pkg::addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] exp_rdata,
                              output logic exp_err);
    exp_rdata = '0;
    exp_err   = 1'b0;
    if ((addr[1:0] == 2'b00) && (addr < 8'h20)) begin
      // Array word counts unless the count is stuck at all ones
      if (write) begin
        model_regs[addr[4:2]] = wdata;
        if (model_wr_cnt != 16'hffff) begin
          model_wr_cnt = model_wr_cnt + 16'd1;
        end
      end else begin
        exp_rdata = model_regs[addr[4:2]];
        if (model_rd_cnt != 16'hffff) begin
          model_rd_cnt = model_rd_cnt + 16'd1;
        end
      end
    end else if ((addr == cdc_reg_pkg::WrCntAddr) || (addr == cdc_reg_pkg::RdCntAddr)) begin
      if (write) begin
        // Either counter address clears both
        model_wr_cnt = '0;
        model_rd_cnt = '0;
      end else if (addr == cdc_reg_pkg::WrCntAddr) begin
        exp_rdata = {16'h0000, model_wr_cnt};
      end else begin
        exp_rdata = {16'h0000, model_rd_cnt};
      end
    end else begin
      // Unmapped or unaligned
      exp_err = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic write, input cdc_reg_pkg::addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    // Setup phase starts once the previous completion is over
    @(negedge clk_src);
    check_value("pready_o", {31'b0, pready}, 32'h0);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    // Access phase held until pready
    @(negedge clk_src);
    penable = 1'b1;
    waited  = 0;
    @(negedge clk_src);
    while (!pready) begin
      if (waited == TimeoutCyc) begin
        abort_run($sformatf("Timeout waiting for pready_o on access to address 0x%02h",
                            addr));
      end
      waited++;
      @(negedge clk_src);
    end
    rdata   = prdata;
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  initial begin
    int          line;
    int          gap;
    logic        wr_flag;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [31:0] rdata;
    logic        err;
    clk_src   = 1'b0;
    clk_dst   = 1'b0;
    rst_src_n = 1'b0;
    rst_dst_n = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    seed      = 35;
    for (int i = 0; i < 8; i++) begin
      model_regs[i] = '0;
    end
    model_wr_cnt = '0;
    model_rd_cnt = '0;
    $readmemh("tb/cdc_reg_testdata.hex", vec_mem);

    // Both resets together
    repeat (4) @(negedge clk_src);
    rst_src_n = 1'b1;
    rst_dst_n = 1'b1;

    // Idle outputs straight out of reset
    @(negedge clk_src);
    check_value("pready_o", {31'b0, pready}, 32'h0);
    check_value("pslverr_o", {31'b0, pslverr}, 32'h0);
    check_value("prdata_o", prdata, 32'h0);

    line = 0;
    while (vec_mem[4*line] !== EndMark) begin
      if (line == MaxLines - 1) begin
        abort_run("Data file has no end marker");
      end
      if (vec_mem[4*line] > 1) begin
        abort_run($sformatf("Data file line %0d has a bad write flag", line));
      end
      wr_flag = vec_mem[4*line][0];
      model_access(wr_flag, vec_mem[4*line+1][7:0], vec_mem[4*line+2], exp_rdata, exp_err);
      // Error column has to agree with the model
      check_value("pslverr_o (data file)", vec_mem[4*line+3], {31'b0, exp_err});
      apb_access(wr_flag, vec_mem[4*line+1][7:0], vec_mem[4*line+2], rdata, err);
      check_value("prdata_o", rdata, exp_rdata);
      check_value("pslverr_o", {31'b0, err}, {31'b0, exp_err});
      // Random idle gap of 0 to 3 cycles with no completion pulse
      gap = $random(seed) & 3;
      repeat (gap) begin
        @(negedge clk_src);
        check_value("pready_o", {31'b0, pready}, 32'h0);
      end
      line++;
    end

    // Last completion pulse has ended
    @(negedge clk_src);
    check_value("pready_o", {31'b0, pready}, 32'h0);
    $display("%0d accesses completed", line);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/cdc_reg_bridge.sv
/*
 * CDC register bridge
 * APB slave in the source clock domain, register file and access counters
 * in the destination clock domain, joined by a REQ/ACK synchronizer
 */
`timescale 1ns/1ps
`default_nettype none

module cdc_reg_bridge #(
  parameter bit EnRzHs  = 1'b0,
  parameter int NumRegs = 8
) (
  input  wire                 clk_src_i,
  input  wire                 rst_src_ni,
  input  wire                 clk_dst_i,
  input  wire                 rst_dst_ni,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  cdc_reg_pkg::addr_t  paddr_i,
  input  cdc_reg_pkg::data_t  pwdata_i,
  output logic                pready_o,
  output cdc_reg_pkg::data_t  prdata_o,
  output logic                pslverr_o
);

  // Handshake
  logic               src_req;
  logic               src_ack;
  logic               dst_req;
  logic               dst_ack;

  // Quasi-static buses, held while the handshake is open
  logic               req_write;
  cdc_reg_pkg::addr_t req_addr;
  cdc_reg_pkg::data_t req_wdata;
  cdc_reg_pkg::data_t rsp_rdata;
  logic               rsp_err;

  // Counter side
  logic               wr_hit;
  logic               rd_hit;
  logic               cnt_clr;
  cdc_reg_pkg::cnt_t  wr_cnt;
  cdc_reg_pkg::cnt_t  rd_cnt;

  //////////////////////////////////////////////////////////////////////
  // Source domain
  //////////////////////////////////////////////////////////////////////

  apb_req_fsm u_apb_req_fsm (
    .clk_src_i   (clk_src_i),
    .rst_src_ni  (rst_src_ni),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .src_ack_i   (src_ack),
    .rsp_rdata_i (rsp_rdata),
    .rsp_err_i   (rsp_err),
    .src_req_o   (src_req),
    .req_write_o (req_write),
    .req_addr_o  (req_addr),
    .req_wdata_o (req_wdata),
    .pready_o    (pready_o),
    .prdata_o    (prdata_o),
    .pslverr_o   (pslverr_o)
  );

  // Crossing
  sync_reqack #(
    .EnRzHs (EnRzHs)
  ) u_sync_reqack (
    .clk_src_i  (clk_src_i),
    .rst_src_ni (rst_src_ni),
    .clk_dst_i  (clk_dst_i),
    .rst_dst_ni (rst_dst_ni),
    .src_req_i  (src_req),
    .src_ack_o  (src_ack),
    .dst_req_o  (dst_req),
    .dst_ack_i  (dst_ack)
  );

  //////////////////////////////////////////////////////////////////////
  // Destination domain
  //////////////////////////////////////////////////////////////////////

  dst_reg_file #(
    .NumRegs (NumRegs)
  ) u_dst_reg_file (
    .clk_dst_i   (clk_dst_i),
    .rst_dst_ni  (rst_dst_ni),
    .dst_req_i   (dst_req),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .wr_cnt_i    (wr_cnt),
    .rd_cnt_i    (rd_cnt),
    .dst_ack_o   (dst_ack),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err),
    .wr_hit_o    (wr_hit),
    .rd_hit_o    (rd_hit),
    .cnt_clr_o   (cnt_clr)
  );

  access_counter u_access_counter (
    .clk_dst_i  (clk_dst_i),
    .rst_dst_ni (rst_dst_ni),
    .wr_hit_i   (wr_hit),
    .rd_hit_i   (rd_hit),
    .clr_i      (cnt_clr),
    .wr_cnt_o   (wr_cnt),
    .rd_cnt_o   (rd_cnt)
  );

endmodule

`default_nettype wire

//--- hdl/access_counter.sv
/*
 * Access counter
 * Saturating write and read counters in the destination domain with clear
 */
`timescale 1ns/1ps
`default_nettype none

module access_counter (
  input  wire                clk_dst_i,
  input  wire                rst_dst_ni,
  input  logic               wr_hit_i,
  input  logic               rd_hit_i,
  input  logic               clr_i,
  output cdc_reg_pkg::cnt_t  wr_cnt_o,
  output cdc_reg_pkg::cnt_t  rd_cnt_o
);

  // Clear wins over a hit, count sticks at all ones
  function automatic cdc_reg_pkg::cnt_t next_cnt(
    input logic              clr,
    input logic              hit,
    input cdc_reg_pkg::cnt_t cnt
  );
    cdc_reg_pkg::cnt_t res;
    res = cnt;
    if (clr) begin
      res = '0;
    end else if (hit && (cnt != '1)) begin
      res = cnt + 1'b1;
    end
    return res;
  endfunction

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      wr_cnt_o <= '0;
      rd_cnt_o <= '0;
    end else begin
      wr_cnt_o <= next_cnt(clr_i, wr_hit_i, wr_cnt_o);
      rd_cnt_o <= next_cnt(clr_i, rd_hit_i, rd_cnt_o);
    end
  end

endmodule

`default_nettype wire

//--- hdl/dst_reg_file.sv
/*
 * Destination register file
 * Word array plus counter readback. Decodes the held request bus on dst_req,
 * answers in the same cycle and holds the response until the next access
 */
`timescale 1ns/1ps
`default_nettype none

module dst_reg_file #(
  parameter int NumRegs = 8
) (
  input  wire                 clk_dst_i,
  input  wire                 rst_dst_ni,
  input  logic                dst_req_i,
  input  logic                req_write_i,
  input  cdc_reg_pkg::addr_t  req_addr_i,
  input  cdc_reg_pkg::data_t  req_wdata_i,
  input  cdc_reg_pkg::cnt_t   wr_cnt_i,
  input  cdc_reg_pkg::cnt_t   rd_cnt_i,
  output logic                dst_ack_o,
  output cdc_reg_pkg::data_t  rsp_rdata_o,
  output logic                rsp_err_o,
  output logic                wr_hit_o,
  output logic                rd_hit_o,
  output logic                cnt_clr_o
);

  localparam int IdxW = (NumRegs > 1) ? $clog2(NumRegs) : 1;

  cdc_reg_pkg::data_t regs_q [NumRegs];
  cdc_reg_pkg::addr_t offset;
  logic [IdxW-1:0]    idx;
  logic               aligned;
  logic               in_array;
  logic               is_wr_cnt;
  logic               is_rd_cnt;
  cdc_reg_pkg::data_t rdata_d;
  logic               err_d;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  assign offset    = req_addr_i - cdc_reg_pkg::RegBase;
  assign aligned   = (req_addr_i[1:0] == 2'b00);
  assign in_array  = aligned && (int'(offset) < NumRegs * 4);
  // Word index inside the array
  assign idx       = offset[IdxW+1:2];
  assign is_wr_cnt = (req_addr_i == cdc_reg_pkg::WrCntAddr);
  assign is_rd_cnt = (req_addr_i == cdc_reg_pkg::RdCntAddr);

  // Answer in the request cycle
  assign dst_ack_o = dst_req_i;

  // Counter strobes, only array accesses count
  assign wr_hit_o  = dst_req_i && req_write_i && in_array;
  assign rd_hit_o  = dst_req_i && !req_write_i && in_array;
  // Write to either counter clears both
  assign cnt_clr_o = dst_req_i && req_write_i && (is_wr_cnt || is_rd_cnt);

  // Response data, zero for writes and errors
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    if (in_array) begin
      if (!req_write_i) begin
        rdata_d = regs_q[idx];
      end
    end else if (is_wr_cnt) begin
      if (!req_write_i) begin
        rdata_d = cdc_reg_pkg::data_t'(wr_cnt_i);
      end
    end else if (is_rd_cnt) begin
      if (!req_write_i) begin
        rdata_d = cdc_reg_pkg::data_t'(rd_cnt_i);
      end
    end else begin
      // Unmapped or unaligned
      err_d = 1'b1;
    end
  end

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
      rsp_rdata_o <= '0;
      rsp_err_o   <= 1'b0;
    end else begin
      if (wr_hit_o) begin
        regs_q[idx] <= req_wdata_i;
      end
      // Response bus only moves on an ACK
      if (dst_ack_o) begin
        rsp_rdata_o <= rdata_d;
        rsp_err_o   <= err_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/apb_req_fsm.sv
/*
 * APB request FSM
 * Source domain APB slave. Captures each access into the held request bus,
 * raises the crossing REQ and completes the transfer once ACK returns
 */
`timescale 1ns/1ps
`default_nettype none

module apb_req_fsm (
  input  wire                 clk_src_i,
  input  wire                 rst_src_ni,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  cdc_reg_pkg::addr_t  paddr_i,
  input  cdc_reg_pkg::data_t  pwdata_i,
  input  logic                src_ack_i,
  input  cdc_reg_pkg::data_t  rsp_rdata_i,
  input  logic                rsp_err_i,
  output logic                src_req_o,
  output logic                req_write_o,
  output cdc_reg_pkg::addr_t  req_addr_o,
  output cdc_reg_pkg::data_t  req_wdata_o,
  output logic                pready_o,
  output cdc_reg_pkg::data_t  prdata_o,
  output logic                pslverr_o
);

  cdc_reg_pkg::apb_state_e state_d, state_q;
  logic                    access_start;
  logic                    rsp_take;
  logic                    err_q;

  // First cycle of the APB access phase
  assign access_start = (state_q == cdc_reg_pkg::Idle) && psel_i && penable_i;
  // ACK pulse ends the wait
  assign rsp_take     = (state_q == cdc_reg_pkg::Wait) && src_ack_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      cdc_reg_pkg::Idle: begin
        if (access_start) begin
          state_d = cdc_reg_pkg::Wait;
        end
      end
      cdc_reg_pkg::Wait: begin
        if (src_ack_i) begin
          state_d = cdc_reg_pkg::Done;
        end
      end
      // Single completion cycle
      cdc_reg_pkg::Done: state_d = cdc_reg_pkg::Idle;
      default:           state_d = cdc_reg_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      state_q     <= cdc_reg_pkg::Idle;
      req_write_o <= 1'b0;
      req_addr_o  <= '0;
      req_wdata_o <= '0;
      prdata_o    <= '0;
      err_q       <= 1'b0;
    end else begin
      state_q <= state_d;
      // Request bus stays put until the next access starts
      if (access_start) begin
        req_write_o <= pwrite_i;
        req_addr_o  <= paddr_i;
        req_wdata_o <= pwdata_i;
      end
      // Response bus has been stable since well before the ACK
      if (rsp_take) begin
        prdata_o <= req_write_o ? '0 : rsp_rdata_i;
        err_q    <= rsp_err_i;
      end
    end
  end

  // REQ held through the whole wait
  assign src_req_o = (state_q == cdc_reg_pkg::Wait);
  assign pready_o  = (state_q == cdc_reg_pkg::Done);
  // Error only shown alongside pready
  assign pslverr_o = pready_o && err_q;

endmodule

`default_nettype wire

//--- sync_reqack/sync_reqack.sv
/*
 * REQ/ACK synchronizer
 * Passes a single REQ from the source clock to the destination clock and the
 * ACK back, each through a two-flop stage. Both sides see one-cycle handshakes.
 * Two-phase NRZ protocol by default, four-phase RZ protocol with EnRzHs set
 */
`timescale 1ns/1ps
`default_nettype none

module sync_reqack #(
  parameter bit EnRzHs = 1'b0
) (
  input  wire  clk_src_i,
  input  wire  rst_src_ni,
  input  wire  clk_dst_i,
  input  wire  rst_dst_ni,
  input  logic src_req_i,
  output logic src_ack_o,
  output logic dst_req_o,
  input  logic dst_ack_i
);

  // Levels that actually cross the clock boundary
  logic       src_req_lvl;
  logic       dst_ack_lvl;

  // Two-flop stages, one per direction
  logic [1:0] req_sync_q;
  logic [1:0] ack_sync_q;
  logic       dst_req_sync;
  logic       src_ack_sync;

  //////////////////////////////////////////////////////////////////////
  // Two-flop synchronizers
  //////////////////////////////////////////////////////////////////////

  // REQ level into the destination domain
  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      req_sync_q <= 2'b00;
    end else begin
      req_sync_q <= {req_sync_q[0], src_req_lvl};
    end
  end

  assign dst_req_sync = req_sync_q[1];

  // ACK level back into the source domain
  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      ack_sync_q <= 2'b00;
    end else begin
      ack_sync_q <= {ack_sync_q[0], dst_ack_lvl};
    end
  end

  assign src_ack_sync = ack_sync_q[1];

  if (EnRzHs) begin : gen_rz
    //////////////////////////////////////////////////////////////////////
    // RZ protocol, both levels return to zero between transactions
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
      LoSt,
      HiSt
    } rz_state_e;

    rz_state_e src_state_d, src_state_q;
    rz_state_e dst_state_d, dst_state_q;

    // Source FSM
    always_comb begin
      src_state_d = src_state_q;
      src_ack_o   = 1'b0;
      unique case (src_state_q)
        LoSt: begin
          // Previous ACK has to be gone before a new REQ goes out
          if (!src_ack_sync && src_req_i) begin
            src_state_d = HiSt;
          end
        end
        HiSt: begin
          src_ack_o = src_ack_sync;
          if (src_ack_sync) begin
            src_state_d = LoSt;
          end
        end
        default: src_state_d = LoSt;
      endcase
    end

    // REQ stays up for the whole HiSt phase
    assign src_req_lvl = (src_state_q == HiSt);

    // Destination FSM
    always_comb begin
      dst_state_d = dst_state_q;
      dst_req_o   = 1'b0;
      unique case (dst_state_q)
        LoSt: begin
          if (dst_req_sync) begin
            dst_req_o = 1'b1;
            if (dst_ack_i) begin
              dst_state_d = HiSt;
            end
          end
        end
        HiSt: begin
          // Hold ACK until the synchronized REQ has dropped
          if (!dst_req_sync) begin
            dst_state_d = LoSt;
          end
        end
        default: dst_state_d = LoSt;
      endcase
    end

    assign dst_ack_lvl = (dst_state_q == HiSt);

    always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
      if (!rst_src_ni) begin
        src_state_q <= LoSt;
      end else begin
        src_state_q <= src_state_d;
      end
    end

    always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
      if (!rst_dst_ni) begin
        dst_state_q <= LoSt;
      end else begin
        dst_state_q <= dst_state_d;
      end
    end

  end else begin : gen_nrz
    //////////////////////////////////////////////////////////////////////
    // NRZ protocol, every toggle of a level is one transaction
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
      PhEven,
      PhOdd
    } nrz_state_e;

    nrz_state_e src_state_d, src_state_q;
    nrz_state_e dst_state_d, dst_state_q;
    logic       src_req_d, src_req_q;
    logic       dst_ack_d, dst_ack_q;

    // Source FSM, in PhOdd the crossing levels are inverted
    always_comb begin
      src_state_d = src_state_q;
      src_req_d   = src_req_q;
      src_ack_o   = 1'b0;
      unique case (src_state_q)
        PhEven: begin
          src_req_d = src_req_i;
          src_ack_o = src_ack_sync;
          if (src_req_i && src_ack_sync) begin
            src_state_d = PhOdd;
          end
        end
        PhOdd: begin
          src_req_d = ~src_req_i;
          src_ack_o = ~src_ack_sync;
          if (src_req_i && !src_ack_sync) begin
            src_state_d = PhEven;
          end
        end
        default: src_state_d = PhEven;
      endcase
    end

    // Destination FSM mirrors the source phase
    always_comb begin
      dst_state_d = dst_state_q;
      dst_ack_d   = dst_ack_q;
      dst_req_o   = 1'b0;
      unique case (dst_state_q)
        PhEven: begin
          dst_req_o = dst_req_sync;
          dst_ack_d = dst_ack_i;
          if (dst_req_sync && dst_ack_i) begin
            dst_state_d = PhOdd;
          end
        end
        PhOdd: begin
          dst_req_o = ~dst_req_sync;
          dst_ack_d = ~dst_ack_i;
          if (!dst_req_sync && dst_ack_i) begin
            dst_state_d = PhEven;
          end
        end
        default: dst_state_d = PhEven;
      endcase
    end

    assign src_req_lvl = src_req_q;
    assign dst_ack_lvl = dst_ack_q;

    always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
      if (!rst_src_ni) begin
        src_state_q <= PhEven;
        src_req_q   <= 1'b0;
      end else begin
        src_state_q <= src_state_d;
        src_req_q   <= src_req_d;
      end
    end

    always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
      if (!rst_dst_ni) begin
        dst_state_q <= PhEven;
        dst_ack_q   <= 1'b0;
      end else begin
        dst_state_q <= dst_state_d;
        dst_ack_q   <= dst_ack_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- common/cdc_reg_pkg.sv
/*
 * CDC register bridge package
 * Shared word types, the destination register map and the APB FSM states
 */
`default_nettype none

package cdc_reg_pkg;

  // APB byte address, register word and counter value
  typedef logic [7:0]  addr_t;
  typedef logic [31:0] data_t;
  typedef logic [15:0] cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////

  // Register array starts here, one word every 4 bytes
  localparam addr_t RegBase   = 8'h00;
  // Access counters, read back zero-extended
  localparam addr_t WrCntAddr = 8'h20;
  localparam addr_t RdCntAddr = 8'h24;

  // Source side APB slave states
  typedef enum logic [1:0] {
    Idle,
    Wait,
    Done
  } apb_state_e;

endpackage

`default_nettype wire
